// ==== rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// PC value after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// Integer register count
`define RV_NREGS 32

`endif

// ==== rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        REG,
        EX,
        MEM
    } fwd_sel_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        word_t     imm;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      we;
        logic      load;
        logic      store;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        logic      use_imm;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      we;
        logic      load;
        logic      store;
        logic      valid;
    } ex_mem_t;

endpackage

// ==== rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_fetch (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_hold,
    input  logic            i_stall,
    input  logic            i_redirect,
    input  rv_pkg::word_t   i_target,
    input  rv_pkg::word_t   i_idt,
    output rv_pkg::word_t   o_iad,
    output rv_pkg::if_id_t  o_if_id
);
    import rv_pkg::*;

    word_t pc_q;
    word_t pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;
    assign o_iad    = pc_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q <= `RV_RESET_PC;
        end else if (!i_hold) begin
            if (i_redirect) begin
                pc_q <= i_target;
            end else if (!i_stall) begin
                pc_q <= pc_plus4;
            end
        end
    end

    // Fetch-to-decode register, squashed on redirect
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_if_id.instr <= `RV_NOP;
            o_if_id.valid <= 1'b0;
        end else if (!i_hold) begin
            if (i_redirect) begin
                o_if_id.instr <= `RV_NOP;
                o_if_id.valid <= 1'b0;
            end else if (!i_stall) begin
                o_if_id.pc    <= pc_q;
                o_if_id.instr <= i_idt;
                o_if_id.valid <= 1'b1;
            end
        end
    end

    // Targets come from execute, so misalignment would show up here
    a_iad_aligned: assert property (
        @(posedge clk) disable iff (i_rst) o_iad[1:0] == 2'b00
    );

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_we,
    input  rv_pkg::reg_addr_t i_waddr,
    input  rv_pkg::word_t     i_wdata,
    input  rv_pkg::reg_addr_t i_raddr1,
    input  rv_pkg::reg_addr_t i_raddr2,
    output rv_pkg::word_t     o_rdata1,
    output rv_pkg::word_t     o_rdata2
);
    import rv_pkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < `RV_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads as zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_hold,
    input  logic              i_redirect,
    input  rv_pkg::if_id_t    i_if_id,
    input  rv_pkg::word_t     i_rdata1,
    input  rv_pkg::word_t     i_rdata2,
    input  rv_pkg::ex_mem_t   i_ex_fwd,
    input  rv_pkg::word_t     i_mem_fwd_data,
    input  rv_pkg::reg_addr_t i_mem_fwd_rd,
    input  logic              i_mem_fwd_we,
    output rv_pkg::reg_addr_t o_raddr1,
    output rv_pkg::reg_addr_t o_raddr2,
    output logic              o_stall,
    output rv_pkg::id_ex_t    o_id_ex
);
    import rv_pkg::*;

    instr_u   ir;
    word_t    imm;
    alu_op_e  alu_op;
    logic     we, load, store, branch, branch_ne, jump, use_imm;
    logic     use_rs1, use_rs2;
    fwd_sel_e fwd1, fwd2;
    word_t    op_a, op_b;

    assign ir       = i_if_id.instr;
    assign o_raddr1 = ir.r.rs1;
    assign o_raddr2 = ir.r.rs2;

    always_comb begin
        imm       = '0;
        alu_op    = ADD;
        we        = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        use_imm   = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (ir.r.opcode)
            OP: begin
                we      = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (ir.r.funct3)
                    3'b000:  alu_op = ir.r.funct7[5] ? SUB : ADD;
                    3'b010:  alu_op = SLT;
                    3'b100:  alu_op = XOR;
                    3'b110:  alu_op = OR;
                    3'b111:  alu_op = AND;
                    default: alu_op = ADD;
                endcase
            end
            OP_IMM: begin
                we      = 1'b1;
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                imm     = {{20{ir.i.imm[11]}}, ir.i.imm};
                case (ir.i.funct3)
                    3'b010:  alu_op = SLT;
                    3'b100:  alu_op = XOR;
                    3'b110:  alu_op = OR;
                    3'b111:  alu_op = AND;
                    default: alu_op = ADD;
                endcase
            end
            LUI: begin
                we      = 1'b1;
                use_imm = 1'b1;
                alu_op  = PASS_B;
                imm     = {ir.u.imm, 12'b0};
            end
            LOAD: begin
                we      = 1'b1;
                load    = 1'b1;
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                imm     = {{20{ir.i.imm[11]}}, ir.i.imm};
            end
            STORE: begin
                store   = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_imm = 1'b1;
                imm     = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            end
            BRANCH: begin
                branch    = 1'b1;
                branch_ne = ir.b.funct3[0];
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm       = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
                             ir.b.imm10_5, ir.b.imm4_1, 1'b0};
            end
            JAL: begin
                we   = 1'b1;
                jump = 1'b1;
                imm  = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12,
                        ir.j.imm11, ir.j.imm10_1, 1'b0};
            end
            default: ;
        endcase
    end

    // Newer EX result takes priority over MEM
    function automatic fwd_sel_e pick_src(input reg_addr_t rs);
        if (rs == '0) begin
            return REG;
        end
        if (i_ex_fwd.valid && i_ex_fwd.we && i_ex_fwd.rd == rs) begin
            return EX;
        end
        if (i_mem_fwd_we && i_mem_fwd_rd == rs) begin
            return MEM;
        end
        return REG;
    endfunction

    function automatic word_t pick_val(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            EX:      return i_ex_fwd.result;
            MEM:     return i_mem_fwd_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd1 = pick_src(ir.r.rs1);
        fwd2 = pick_src(ir.r.rs2);
        op_a = pick_val(fwd1, i_rdata1);
        op_b = pick_val(fwd2, i_rdata2);
    end

    // Load result not ready until the memory stage
    assign o_stall = i_if_id.valid && i_ex_fwd.load && i_ex_fwd.we && i_ex_fwd.rd != '0
                     && ((use_rs1 && i_ex_fwd.rd == ir.r.rs1)
                      || (use_rs2 && i_ex_fwd.rd == ir.r.rs2));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex.valid <= 1'b0;
        end else if (!i_hold) begin
            o_id_ex.pc         <= i_if_id.pc;
            o_id_ex.op_a       <= op_a;
            o_id_ex.op_b       <= op_b;
            o_id_ex.store_data <= op_b;
            o_id_ex.imm        <= imm;
            o_id_ex.rd         <= ir.r.rd;
            o_id_ex.alu_op     <= alu_op;
            o_id_ex.we         <= we;
            o_id_ex.load       <= load;
            o_id_ex.store      <= store;
            o_id_ex.branch     <= branch;
            o_id_ex.branch_ne  <= branch_ne;
            o_id_ex.jump       <= jump;
            o_id_ex.use_imm    <= use_imm;
            // Bubble on stall or squash
            o_id_ex.valid      <= i_if_id.valid && !i_redirect && !o_stall;
        end
    end

    // A load in execute cannot also redirect
    a_stall_excludes_redirect: assert property (
        @(posedge clk) disable iff (i_rst)
        !(o_stall && i_redirect)
    );

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_hold,
    input  rv_pkg::id_ex_t  i_id_ex,
    output logic            o_redirect,
    output rv_pkg::word_t   o_target,
    output rv_pkg::ex_mem_t o_ex_fwd,
    output rv_pkg::ex_mem_t o_ex_mem
);
    import rv_pkg::*;

    word_t alu_b;
    word_t alu_out;
    word_t pc_plus4;
    logic  operands_eq;

    always_comb begin
        alu_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.op_b;
        case (i_id_ex.alu_op)
            ADD:     alu_out = i_id_ex.op_a + alu_b;
            SUB:     alu_out = i_id_ex.op_a - alu_b;
            AND:     alu_out = i_id_ex.op_a & alu_b;
            OR:      alu_out = i_id_ex.op_a | alu_b;
            XOR:     alu_out = i_id_ex.op_a ^ alu_b;
            SLT:     alu_out = {31'b0, $signed(i_id_ex.op_a) < $signed(alu_b)};
            PASS_B:  alu_out = alu_b;
            default: alu_out = i_id_ex.op_a + alu_b;
        endcase
    end

    assign pc_plus4    = i_id_ex.pc + 32'd4;
    assign operands_eq = (i_id_ex.op_a == i_id_ex.op_b);

    // beq when branch_ne is low, bne otherwise
    assign o_redirect = i_id_ex.valid
                        && (i_id_ex.jump
                         || (i_id_ex.branch && (operands_eq != i_id_ex.branch_ne)));
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

    // Result as seen by decode for forwarding
    always_comb begin
        o_ex_fwd.result     = i_id_ex.jump ? pc_plus4 : alu_out;
        o_ex_fwd.store_data = i_id_ex.store_data;
        o_ex_fwd.rd         = i_id_ex.rd;
        o_ex_fwd.we         = i_id_ex.valid && i_id_ex.we;
        o_ex_fwd.load       = i_id_ex.valid && i_id_ex.load;
        o_ex_fwd.store      = i_id_ex.valid && i_id_ex.store;
        o_ex_fwd.valid      = i_id_ex.valid;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_mem.valid <= 1'b0;
        end else if (!i_hold) begin
            o_ex_mem <= o_ex_fwd;
        end
    end

endmodule

// ==== rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
    input  logic              clk,
    input  logic              i_rst,
    input  rv_pkg::ex_mem_t   i_ex_mem,
    input  logic              i_acki_n,
    input  logic              i_ackd_n,
    input  rv_pkg::word_t     i_ddt_rd,
    output logic              o_hold,
    output rv_pkg::word_t     o_dad,
    output rv_pkg::word_t     o_ddt_wr,
    output logic              o_mreq,
    output logic              o_write,
    output logic              o_wb_we,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);

    // Data bus
    assign o_mreq   = i_ex_mem.valid && (i_ex_mem.load || i_ex_mem.store);
    assign o_write  = i_ex_mem.valid && i_ex_mem.store;
    assign o_dad    = i_ex_mem.result;
    assign o_ddt_wr = i_ex_mem.store_data;

    // Freeze everything until both memories answer
    assign o_hold = i_acki_n || (o_mreq && i_ackd_n);

    // Load data taken at the acknowledging edge
    assign o_wb_data = i_ex_mem.load ? i_ddt_rd : i_ex_mem.result;
    assign o_wb_rd   = i_ex_mem.rd;
    assign o_wb_we   = i_ex_mem.valid && i_ex_mem.we && !o_hold;

    a_dad_stable: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_mreq && o_hold) |=> $stable(o_dad)
    );

    a_ddt_wr_stable: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_write && o_hold) |=> $stable(o_ddt_wr)
    );

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic          clk,
    input  logic          i_rst,
    output rv_pkg::word_t o_iad,
    input  rv_pkg::word_t i_idt,
    input  logic          i_acki_n,
    output rv_pkg::word_t o_dad,
    input  rv_pkg::word_t i_ddt_rd,
    output rv_pkg::word_t o_ddt_wr,
    output logic          o_mreq,
    output logic          o_write,
    input  logic          i_ackd_n
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_fwd;
    ex_mem_t   ex_mem;
    logic      hold;
    logic      stall;
    logic      redirect;
    word_t     target;
    reg_addr_t raddr1, raddr2;
    word_t     rdata1, rdata2;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rv_fetch rv_fetch_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_hold     (hold),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .i_idt      (i_idt),
        .o_iad      (o_iad),
        .o_if_id    (if_id)
    );

    rv_decode rv_decode_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_hold         (hold),
        .i_redirect     (redirect),
        .i_if_id        (if_id),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .i_ex_fwd       (ex_fwd),
        .i_mem_fwd_data (wb_data),
        .i_mem_fwd_rd   (wb_rd),
        .i_mem_fwd_we   (wb_we),
        .o_raddr1       (raddr1),
        .o_raddr2       (raddr2),
        .o_stall        (stall),
        .o_id_ex        (id_ex)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_we     (wb_we),
        .i_waddr  (wb_rd),
        .i_wdata  (wb_data),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    rv_execute rv_execute_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_hold     (hold),
        .i_id_ex    (id_ex),
        .o_redirect (redirect),
        .o_target   (target),
        .o_ex_fwd   (ex_fwd),
        .o_ex_mem   (ex_mem)
    );

    rv_mem_wb rv_mem_wb_inst (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_ex_mem  (ex_mem),
        .i_acki_n  (i_acki_n),
        .i_ackd_n  (i_ackd_n),
        .i_ddt_rd  (i_ddt_rd),
        .o_hold    (hold),
        .o_dad     (o_dad),
        .o_ddt_wr  (o_ddt_wr),
        .o_mreq    (o_mreq),
        .o_write   (o_write),
        .o_wb_we   (wb_we),
        .o_wb_rd   (wb_rd),
        .o_wb_data (wb_data)
    );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core;
    import rv_pkg::*;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam int PROG_LEN       = 28;
    localparam int NUM_STORES     = 6;
    localparam int DMEM_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 * (3 + 1) + 200;

    logic  clk = 1'b0;
    logic  i_rst;
    word_t o_iad;
    word_t i_idt;
    logic  i_acki_n;
    word_t o_dad;
    word_t i_ddt_rd;
    word_t o_ddt_wr;
    logic  o_mreq;
    logic  o_write;
    logic  i_ackd_n;

    word_t  prog [PROG_LEN];
    word_t  dmem [DMEM_WORDS];
    store_t exp_stores [NUM_STORES];

    int    iwait;
    int    dwait;
    logic  dwait_active;
    logic  d_complete;
    logic  pend_valid;
    logic  pend_write;
    word_t pend_dad;
    word_t pend_wr;
    int    store_idx;
    int    cycle_count;

    rv_core_top rv_core_top_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .o_iad    (o_iad),
        .i_idt    (i_idt),
        .i_acki_n (i_acki_n),
        .o_dad    (o_dad),
        .i_ddt_rd (i_ddt_rd),
        .o_ddt_wr (o_ddt_wr),
        .o_mreq   (o_mreq),
        .o_write  (o_write),
        .i_ackd_n (i_ackd_n)
    );

    always #4 clk = ~clk;

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
        if (act_val !== exp_val) begin
            $display("mismatch %s expected %h got %h", name, exp_val, act_val);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("mismatch %s expected %h got %h", name, exp_val, act_val);
            stop_on_failure();
        end
    endtask

    // Addresses past the program read as NOP
    function automatic word_t fetch_word(input word_t addr);
        if (addr[31:2] < PROG_LEN) begin
            return prog[addr[31:2]];
        end
        return `RV_NOP;
    endfunction

    task automatic load_tables();
        prog[0]  = 32'h0800_0093;  // addi x1, x0, 128
        prog[1]  = 32'h1234_5137;  // lui  x2, 0x12345
        prog[2]  = 32'h6781_0113;  // addi x2, x2, 0x678
        prog[3]  = 32'hFFF1_4193;  // xori x3, x2, -1
        prog[4]  = 32'h0031_0233;  // add  x4, x2, x3
        prog[5]  = 32'h0040_A023;  // sw   x4, 0(x1)
        prog[6]  = 32'h4021_82B3;  // sub  x5, x3, x2
        prog[7]  = 32'h0050_A223;  // sw   x5, 4(x1)
        prog[8]  = 32'h0002_A313;  // slti x6, x5, 0
        prog[9]  = 32'h0A03_6393;  // ori  x7, x6, 0xa0
        prog[10] = 32'h0023_E433;  // or   x8, x7, x2
        prog[11] = 32'h0054_74B3;  // and  x9, x8, x5
        prog[12] = 32'h0021_A533;  // slt  x10, x3, x2
        prog[13] = 32'h00A4_84B3;  // add  x9, x9, x10
        prog[14] = 32'h0090_A423;  // sw   x9, 8(x1)
        prog[15] = 32'h0000_A583;  // lw   x11, 0(x1)
        prog[16] = 32'h0025_8633;  // add  x12, x11, x2
        prog[17] = 32'h00C0_A623;  // sw   x12, 12(x1)
        prog[18] = 32'h0045_8663;  // beq  x11, x4, +12
        prog[19] = 32'h0030_A823;  // sw   x3, 16(x1)
        prog[20] = 32'h0030_AA23;  // sw   x3, 20(x1)
        prog[21] = 32'h0021_1463;  // bne  x2, x2, +8
        prog[22] = 32'h0060_A823;  // sw   x6, 16(x1)
        prog[23] = 32'h00C0_06EF;  // jal  x13, +12
        prog[24] = 32'h0030_AA23;  // sw   x3, 20(x1)
        prog[25] = 32'h0030_AC23;  // sw   x3, 24(x1)
        prog[26] = 32'h00D0_AA23;  // sw   x13, 20(x1)
        prog[27] = 32'h0000_006F;  // jal  x0, 0
        // Stores in program order; sw x3 slots are skipped by beq and jal
        exp_stores[0] = {32'h0000_0080, 32'hFFFF_FFFF};
        exp_stores[1] = {32'h0000_0084, 32'hDB97_530F};
        exp_stores[2] = {32'h0000_0088, 32'h1214_520A};
        exp_stores[3] = {32'h0000_008C, 32'h1234_5677};
        exp_stores[4] = {32'h0000_0090, 32'h0000_0001};
        exp_stores[5] = {32'h0000_0094, 32'h0000_0060};
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = 32'hD00D_0000 ^ (k << 2);
        end
    endtask

    // Both memories answer after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        i_idt = fetch_word(o_iad);
        if (!i_acki_n) begin
            iwait = $urandom % 4;
        end else if (iwait != 0) begin
            iwait--;
        end
        i_acki_n = (iwait != 0);

        i_ddt_rd = dmem[o_dad[7:2]];
        if (!o_mreq) begin
            dwait_active = 1'b0;
            i_ackd_n     = 1'b1;
        end else begin
            if (!dwait_active) begin
                dwait        = $urandom % 4;
                dwait_active = 1'b1;
            end else if (dwait != 0) begin
                dwait--;
            end
            i_ackd_n = (dwait != 0);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("program did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // Inputs only move 1 ns after the edge, so the negedge sees the next edge's values
    always @(negedge clk) begin
        d_complete = o_mreq && !i_ackd_n && !i_acki_n;

        // Reset and the first cycle after it
        if (cycle_count >= 1 && cycle_count <= 16) begin
            check_word("o_iad", `RV_RESET_PC, o_iad);
            check_bit("o_mreq", 1'b0, o_mreq);
            check_bit("o_write", 1'b0, o_write);
        end

        if (pend_valid) begin
            check_bit("o_mreq", 1'b1, o_mreq);
            check_word("o_dad", pend_dad, o_dad);
            if (pend_write) begin
                check_word("o_ddt_wr", pend_wr, o_ddt_wr);
            end
        end

        if (d_complete && o_write) begin
            if (store_idx >= NUM_STORES) begin
                $display("unexpected store to %h after the last expected one", o_dad);
                stop_on_failure();
            end else begin
                check_word("o_dad", exp_stores[store_idx].addr, o_dad);
                check_word("o_ddt_wr", exp_stores[store_idx].data, o_ddt_wr);
                dmem[o_dad[7:2]] = o_ddt_wr;
                store_idx++;
            end
        end

        if (d_complete) begin
            dwait_active = 1'b0;
        end
        pend_valid = o_mreq && !d_complete;
        pend_write = o_write;
        pend_dad   = o_dad;
        pend_wr    = o_ddt_wr;
    end

    initial begin
        void'($urandom(32'h8251));
        i_rst        = 1'b1;
        i_idt        = `RV_NOP;
        i_acki_n     = 1'b1;
        i_ddt_rd     = '0;
        i_ackd_n     = 1'b1;
        iwait        = 0;
        dwait        = 0;
        dwait_active = 1'b0;
        pend_valid   = 1'b0;
        pend_write   = 1'b0;
        pend_dad     = '0;
        pend_wr      = '0;
        store_idx    = 0;
        cycle_count  = 0;
        load_tables();

        repeat (16) @(posedge clk);
        #1;
        i_rst = 1'b0;

        wait (store_idx == NUM_STORES);
        // Window in which a stray store would still be caught
        repeat (20) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_core_top.sv
tb_rv_core.sv
